// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int xlen = 32;

  // RV32E has only 16 integer registers
  typedef logic [3:0] reg_idx_t;

  // register and immediate field view
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  // upper immediate view
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_up_t;

  typedef union packed {
    inst_r_t  r;
    inst_up_t u;
  } inst_u;

  // ========================================
  // major opcodes
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 selectors
  localparam logic [2:0] f3_add   = 3'b000;
  localparam logic [2:0] f3_lw    = 3'b010;
  localparam logic [2:0] f3_lbu   = 3'b100;
  localparam logic [2:0] f3_sw    = 3'b010;
  localparam logic [2:0] f3_sb    = 3'b000;
  localparam logic [2:0] f3_csrrw = 3'b001;
  localparam logic [2:0] f3_csrrs = 3'b010;

  // CSR addresses
  localparam logic [11:0] csr_mcycle    = 12'hb00;
  localparam logic [11:0] csr_mcycleh   = 12'hb80;
  localparam logic [11:0] csr_mvendorid = 12'hf11;
  localparam logic [11:0] csr_marchid   = 12'hf12;

endpackage

// File: common/mem_bus_pkg.sv
package mem_bus_pkg;

  // data lanes on the memory bus
  localparam int bus_dw = 32;

  // one enable bit per byte lane
  typedef logic [3:0] byte_mask_t;

  // transfer size, log2 of the byte count
  typedef logic [1:0] size_t;

  localparam size_t size_byte = 2'b00;
  localparam size_t size_word = 2'b10;

endpackage

// File: hdl/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit #(
  parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = 32'h3000_0000
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        retire,
  input  logic [rv_isa_pkg::xlen-1:0] next_pc,
  output logic                        ifu_req,
  output logic [rv_isa_pkg::xlen-1:0] ifu_addr,
  input  logic                        ifu_resp,
  input  logic [rv_isa_pkg::xlen-1:0] ifu_rdata,
  output logic [rv_isa_pkg::xlen-1:0] pc,
  output rv_isa_pkg::inst_u           inst,
  output logic                        inst_valid
);
  localparam logic st_idle = 1'b0;
  localparam logic st_wait = 1'b1;

  logic state;
  logic pc_valid;

  // pc_valid means a fresh pc is waiting to be fetched
  always_ff @(posedge clk) begin
    if (rst) begin
      pc       <= reset_pc;
      pc_valid <= 1'b1;
    end else if (retire) begin
      pc       <= next_pc;
      pc_valid <= 1'b1;
    end else if (state == st_idle && pc_valid) begin
      pc_valid <= 1'b0;
    end
  end

  // ========================================
  // fetch FSM, one request outstanding
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      ifu_req    <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      inst_valid <= 1'b0;
      ifu_req    <= 1'b0;
      if (state == st_idle) begin
        if (pc_valid) begin
          ifu_req <= 1'b1;
          state   <= st_wait;
        end
      end else if (ifu_resp) begin
        inst_valid <= 1'b1;
        state      <= st_idle;
      end
    end
  end

  // address and fetched word are plain payload
  always_ff @(posedge clk) begin
    if (state == st_idle && pc_valid) begin
      ifu_addr <= pc;
    end
    if (state == st_wait && ifu_resp) begin
      inst <= ifu_rdata;
    end
  end

endmodule

// File: hdl/decoder.sv
`timescale 1ns/10ps

module decoder (
  input  rv_isa_pkg::inst_u           inst,
  output logic                        is_add,
  output logic                        is_addi,
  output logic                        is_lw,
  output logic                        is_lbu,
  output logic                        is_sw,
  output logic                        is_sb,
  output logic                        is_lui,
  output logic                        is_jalr,
  output logic                        is_csrrw,
  output logic                        is_csrrs,
  output rv_isa_pkg::reg_idx_t        rs1,
  output rv_isa_pkg::reg_idx_t        rs2,
  output rv_isa_pkg::reg_idx_t        rd,
  output logic [rv_isa_pkg::xlen-1:0] imm,
  output logic [11:0]                 csr_addr,
  output mem_bus_pkg::byte_mask_t     wmask
);
  import rv_isa_pkg::*;

  logic [xlen-1:0] imm_i, imm_s, imm_u;

  // only the low 4 bits index the RV32E file
  assign rs1 = inst.r.rs1[3:0];
  assign rs2 = inst.r.rs2[3:0];
  assign rd  = inst.r.rd[3:0];

  assign csr_addr = {inst.r.funct7, inst.r.rs2};

  assign imm_i = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rs2};
  assign imm_s = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rd};
  assign imm_u = {inst.u.imm, 12'b0};

  // ========================================
  // operation strobes
  always_comb begin
    is_add   = 1'b0;
    is_addi  = 1'b0;
    is_lw    = 1'b0;
    is_lbu   = 1'b0;
    is_sw    = 1'b0;
    is_sb    = 1'b0;
    is_lui   = 1'b0;
    is_jalr  = 1'b0;
    is_csrrw = 1'b0;
    is_csrrs = 1'b0;
    case (inst.r.opcode)
      op_op:     is_add = inst.r.funct3 == f3_add && inst.r.funct7 == 7'b0;
      op_imm:    is_addi = inst.r.funct3 == f3_add;
      op_load: begin
        is_lw  = inst.r.funct3 == f3_lw;
        is_lbu = inst.r.funct3 == f3_lbu;
      end
      op_store: begin
        is_sw = inst.r.funct3 == f3_sw;
        is_sb = inst.r.funct3 == f3_sb;
      end
      op_lui:    is_lui = 1'b1;
      op_jalr:   is_jalr = 1'b1;
      op_system: begin
        is_csrrw = inst.r.funct3 == f3_csrrw;
        is_csrrs = inst.r.funct3 == f3_csrrs;
      end
      // anything else falls through as a no-op
      default: ;
    endcase
  end

  // immediate by format, I type by default
  assign imm = (is_sw || is_sb) ? imm_s :
               is_lui           ? imm_u : imm_i;

  assign wmask = is_sw ? 4'b1111 :
                 is_sb ? 4'b0001 : 4'b0000;

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wen,
  input  rv_isa_pkg::reg_idx_t        waddr,
  input  logic [rv_isa_pkg::xlen-1:0] wdata,
  input  rv_isa_pkg::reg_idx_t        raddr1,
  input  rv_isa_pkg::reg_idx_t        raddr2,
  output logic [rv_isa_pkg::xlen-1:0] rdata1,
  output logic [rv_isa_pkg::xlen-1:0] rdata2
);
  import rv_isa_pkg::*;

  logic [xlen-1:0] regs [16];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 is hardwired to zero on read
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: hdl/csr_file.sv
`timescale 1ns/10ps

module csr_file #(
  parameter logic [rv_isa_pkg::xlen-1:0] vendor_id = 32'h7973_7978,
  parameter logic [rv_isa_pkg::xlen-1:0] arch_id   = 32'h017e_b18a
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [11:0]                 csr_addr,
  input  logic                        we,
  input  logic                        set,
  input  logic [rv_isa_pkg::xlen-1:0] wdata,
  output logic [rv_isa_pkg::xlen-1:0] rdata
);
  import rv_isa_pkg::*;

  logic [63:0] mcycle;

  always_comb begin
    case (csr_addr)
      csr_mcycle:    rdata = mcycle[31:0];
      csr_mcycleh:   rdata = mcycle[63:32];
      csr_mvendorid: rdata = vendor_id;
      csr_marchid:   rdata = arch_id;
      default:       rdata = '0;
    endcase
  end

  // a software write overrides the increment for that half
  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle <= '0;
    end else begin
      mcycle <= mcycle + 64'd1;
      if (we) begin
        if (csr_addr == csr_mcycle) mcycle[31:0] <= wdata;
        if (csr_addr == csr_mcycleh) mcycle[63:32] <= wdata;
      end else if (set && wdata != '0) begin
        if (csr_addr == csr_mcycle) mcycle[31:0] <= mcycle[31:0] | wdata;
        if (csr_addr == csr_mcycleh) mcycle[63:32] <= mcycle[63:32] | wdata;
      end
    end
  end

endmodule

// File: hdl/execute_writeback.sv
`timescale 1ns/10ps

module execute_writeback (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        inst_valid,
  input  logic                        is_add,
  input  logic                        is_addi,
  input  logic                        is_lw,
  input  logic                        is_lbu,
  input  logic                        is_sw,
  input  logic                        is_sb,
  input  logic                        is_lui,
  input  logic                        is_jalr,
  input  logic                        is_csrrw,
  input  logic                        is_csrrs,
  input  logic [rv_isa_pkg::xlen-1:0] rs1_data,
  input  logic [rv_isa_pkg::xlen-1:0] rs2_data,
  input  logic [rv_isa_pkg::xlen-1:0] imm,
  input  logic [rv_isa_pkg::xlen-1:0] pc,
  input  logic [rv_isa_pkg::xlen-1:0] csr_rdata,
  input  logic [rv_isa_pkg::xlen-1:0] load_data,
  input  logic                        mem_done,
  output logic [rv_isa_pkg::xlen-1:0] alu_out,
  output logic                        mem_start,
  output logic                        retire,
  output logic [rv_isa_pkg::xlen-1:0] next_pc,
  output logic                        rf_wen,
  output logic [rv_isa_pkg::xlen-1:0] rd_data,
  output logic                        csr_we,
  output logic                        csr_set,
  output logic [rv_isa_pkg::xlen-1:0] csr_wdata
);
  import rv_isa_pkg::*;

  localparam logic st_idle = 1'b0;
  localparam logic st_mem  = 1'b1;

  logic            state;
  logic            alu_retire;
  logic            is_load, is_mem, is_csr, writes_rd;
  logic [xlen-1:0] op_a, op_b, pc_plus4;

  assign is_load   = is_lw | is_lbu;
  assign is_mem    = is_load | is_sw | is_sb;
  assign is_csr    = is_csrrw | is_csrrs;
  assign writes_rd = is_add | is_addi | is_load | is_lui | is_jalr | is_csr;

  // ========================================
  // single adder for arithmetic and addresses
  assign op_a     = is_lui ? '0 : rs1_data;
  assign op_b     = is_add ? rs2_data : imm;
  assign alu_out  = op_a + op_b;
  assign pc_plus4 = pc + 32'd4;

  assign mem_start = inst_valid & is_mem;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      alu_retire <= 1'b0;
    end else begin
      alu_retire <= inst_valid & ~is_mem;
      if (state == st_idle && mem_start) state <= st_mem;
      else if (state == st_mem && mem_done) state <= st_idle;
    end
  end

  assign retire = alu_retire | (state == st_mem && mem_done);

  // writeback, valid only in the retire cycle
  assign next_pc   = is_jalr ? {alu_out[xlen-1:1], 1'b0} : pc_plus4;
  assign rd_data   = is_jalr ? pc_plus4 :
                     is_csr  ? csr_rdata :
                     is_load ? load_data : alu_out;
  assign rf_wen    = retire & writes_rd;
  assign csr_we    = retire & is_csrrw;
  assign csr_set   = retire & is_csrrs;
  assign csr_wdata = rs1_data;

endmodule

// File: lsu/load_store_unit.sv
`timescale 1ns/10ps

module load_store_unit (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           mem_start,
  input  logic                           is_lw,
  input  logic                           is_lbu,
  input  logic                           is_sw,
  input  logic                           is_sb,
  input  logic [rv_isa_pkg::xlen-1:0]    alu_out,
  input  logic [rv_isa_pkg::xlen-1:0]    rs2_data,
  input  mem_bus_pkg::byte_mask_t        wmask,
  output logic                           mem_done,
  output logic [rv_isa_pkg::xlen-1:0]    load_data,
  output logic                           lsu_req,
  output logic [rv_isa_pkg::xlen-1:0]    lsu_addr,
  output logic                           lsu_wen,
  output logic [mem_bus_pkg::bus_dw-1:0] lsu_wdata,
  output mem_bus_pkg::byte_mask_t        lsu_wmask,
  output mem_bus_pkg::size_t             lsu_size,
  input  logic                           lsu_resp,
  input  logic [mem_bus_pkg::bus_dw-1:0] lsu_rdata
);
  import mem_bus_pkg::*;

  logic              busy;
  logic [bus_dw-1:0] rdata_shift;

  // move the addressed lane down to bit 0
  assign rdata_shift = lsu_rdata >> {lsu_addr[1:0], 3'b000};

  always_ff @(posedge clk) begin
    if (rst) begin
      lsu_req  <= 1'b0;
      lsu_wen  <= 1'b0;
      busy     <= 1'b0;
      mem_done <= 1'b0;
    end else begin
      lsu_req  <= mem_start;
      mem_done <= lsu_resp & busy;
      if (mem_start) begin
        busy    <= 1'b1;
        lsu_wen <= is_sw | is_sb;
      end else if (lsu_resp) begin
        busy    <= 1'b0;
        lsu_wen <= 1'b0;
      end
    end
  end

  // ========================================
  // request payload and load result
  always_ff @(posedge clk) begin
    if (mem_start) begin
      lsu_addr  <= alu_out;
      lsu_wdata <= rs2_data << {alu_out[1:0], 3'b000};
      lsu_wmask <= wmask << alu_out[1:0];
      lsu_size  <= (is_sb || is_lbu) ? size_byte : size_word;
    end
    if (lsu_resp && busy) begin
      load_data <= is_lbu ? {24'b0, rdata_shift[7:0]} :
                   is_lw  ? rdata_shift : '0;
    end
  end

endmodule

// File: hdl/core.sv
`timescale 1ns/10ps

module core #(
  parameter logic [rv_isa_pkg::xlen-1:0] reset_pc  = 32'h3000_0000,
  parameter logic [rv_isa_pkg::xlen-1:0] vendor_id = 32'h7973_7978,
  parameter logic [rv_isa_pkg::xlen-1:0] arch_id   = 32'h017e_b18a
) (
  input  logic                                clk,
  input  logic                                rst,
  // instruction bus
  output logic                                ifu_req,
  output logic [rv_isa_pkg::xlen-1:0]         ifu_addr,
  input  logic                                ifu_resp,
  input  logic [rv_isa_pkg::xlen-1:0]         ifu_rdata,
  // data bus
  output logic                                lsu_req,
  output logic [rv_isa_pkg::xlen-1:0]         lsu_addr,
  output logic                                lsu_wen,
  output logic [mem_bus_pkg::bus_dw-1:0]      lsu_wdata,
  output mem_bus_pkg::byte_mask_t             lsu_wmask,
  output mem_bus_pkg::size_t                  lsu_size,
  input  logic                                lsu_resp,
  input  logic [mem_bus_pkg::bus_dw-1:0]      lsu_rdata
);
  import rv_isa_pkg::*;
  import mem_bus_pkg::*;

  logic [xlen-1:0] pc, next_pc, imm, alu_out, load_data;
  logic [xlen-1:0] rs1_data, rs2_data, rd_data;
  logic [xlen-1:0] csr_rdata, csr_wdata;
  logic [11:0]     csr_addr;
  inst_u           inst;
  reg_idx_t        rs1, rs2, rd;
  byte_mask_t      wmask;
  logic inst_valid, retire, mem_start, mem_done;
  logic rf_wen, csr_we, csr_set;
  logic is_add, is_addi, is_lw, is_lbu, is_sw, is_sb;
  logic is_lui, is_jalr, is_csrrw, is_csrrs;

  fetch_unit #(.reset_pc(reset_pc)) fetch_i (
    .clk, .rst, .retire, .next_pc,
    .ifu_req, .ifu_addr, .ifu_resp, .ifu_rdata,
    .pc, .inst, .inst_valid
  );

  decoder decoder_i (
    .inst,
    .is_add, .is_addi, .is_lw, .is_lbu, .is_sw, .is_sb,
    .is_lui, .is_jalr, .is_csrrw, .is_csrrs,
    .rs1, .rs2, .rd, .imm, .csr_addr, .wmask
  );

  reg_file reg_file_i (
    .clk, .rst, .wen(rf_wen), .waddr(rd), .wdata(rd_data),
    .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data)
  );

  csr_file #(.vendor_id(vendor_id), .arch_id(arch_id)) csr_i (
    .clk, .rst, .csr_addr, .we(csr_we), .set(csr_set),
    .wdata(csr_wdata), .rdata(csr_rdata)
  );

  execute_writeback exwb_i (
    .clk, .rst, .inst_valid,
    .is_add, .is_addi, .is_lw, .is_lbu, .is_sw, .is_sb,
    .is_lui, .is_jalr, .is_csrrw, .is_csrrs,
    .rs1_data, .rs2_data, .imm, .pc, .csr_rdata, .load_data, .mem_done,
    .alu_out, .mem_start, .retire, .next_pc, .rf_wen, .rd_data,
    .csr_we, .csr_set, .csr_wdata
  );

  load_store_unit lsu_i (
    .clk, .rst, .mem_start, .is_lw, .is_lbu, .is_sw, .is_sb,
    .alu_out, .rs2_data, .wmask, .mem_done, .load_data,
    .lsu_req, .lsu_addr, .lsu_wen, .lsu_wdata, .lsu_wmask, .lsu_size,
    .lsu_resp, .lsu_rdata
  );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int period_ns = 20
) (
  output logic clk
);

  initial clk = 1'b0;

  // free running, first rising edge at half a period
  always #(period_ns / 2) clk = ~clk;

endmodule

// File: dv/core_properties.sv
`timescale 1ns/10ps

module core_properties (
  input logic clk,
  input logic rst,
  input logic ifu_req,
  input logic ifu_resp,
  input logic lsu_req,
  input logic lsu_resp
);

  logic ifu_pend;
  logic lsu_pend;

  // outstanding request trackers
  always_ff @(posedge clk) begin
    if (rst) begin
      ifu_pend <= 1'b0;
      lsu_pend <= 1'b0;
    end else begin
      if (ifu_req) ifu_pend <= 1'b1;
      else if (ifu_resp) ifu_pend <= 1'b0;
      if (lsu_req) lsu_pend <= 1'b1;
      else if (lsu_resp) lsu_pend <= 1'b0;
    end
  end

  // ========================================
  // bus rules
  assert property (@(posedge clk) disable iff (rst) !(ifu_req && lsu_req))
    else $error("fetch and data requests are high together");

  assert property (@(posedge clk) disable iff (rst) ifu_req |-> !ifu_pend)
    else $error("second fetch request before the response");

  assert property (@(posedge clk) disable iff (rst) lsu_req |-> !lsu_pend)
    else $error("second data request before the response");

  assert property (@(posedge clk) rst |=> (!ifu_req && !lsu_req))
    else $error("bus request high during reset");

endmodule

bind core core_properties core_props_i (
  .clk(clk), .rst(rst),
  .ifu_req(ifu_req), .ifu_resp(ifu_resp),
  .lsu_req(lsu_req), .lsu_resp(lsu_resp)
);

// File: dv/tb_core.sv
`timescale 1ns/10ps

module tb_core;
  import rv_isa_pkg::*;

  localparam logic [31:0] prog_base = 32'h3000_0000;
  localparam logic [31:0] tb_vendor = 32'h1234_abcd;
  localparam logic [31:0] tb_arch   = 32'h0bad_c0de;
  localparam int          max_cycles = 4000;

  // transfer size is log2 of the byte count
  localparam logic [1:0]  sz_byte = 2'b00;
  localparam logic [1:0]  sz_word = 2'b10;

  logic        clk, rst;
  logic        ifu_req, ifu_resp, lsu_req, lsu_resp, lsu_wen;
  logic [31:0] ifu_addr, ifu_rdata, lsu_addr, lsu_wdata, lsu_rdata;
  logic [3:0]  lsu_wmask;
  logic [1:0]  lsu_size;

  logic [31:0] imem [64];
  logic [31:0] dmem [256];
  logic [31:0] wr_addr [$];
  logic [31:0] wr_data [$];
  logic [3:0]  wr_mask [$];
  logic [1:0]  req_size [$];
  logic [31:0] fetch_log [$];
  logic [31:0] seed = 32'h68da_1c12;
  int          prog_len, errors, checks, cycles;

  tb_clock_gen #(.period_ns(20)) clk_gen_i (.clk(clk));

  core #(.reset_pc(prog_base), .vendor_id(tb_vendor), .arch_id(tb_arch)) core_i (
    .clk, .rst,
    .ifu_req, .ifu_addr, .ifu_resp, .ifu_rdata,
    .lsu_req, .lsu_addr, .lsu_wen, .lsu_wdata, .lsu_wmask, .lsu_size,
    .lsu_resp, .lsu_rdata
  );

  // ========================================
  // helpers
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic logic [31:0] fill_word(logic [31:0] idx);
    return (idx * 32'h9e37_79b9) ^ 32'h5a5a_1234;
  endfunction

  function automatic logic [31:0] rtype(logic [4:0] rs2, logic [4:0] rs1, logic [4:0] rd);
    return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] itype(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] stype(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] utype(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic emit(logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // hold reset, clear memories and logs, then take a new program
  task automatic begin_prog();
    @(posedge clk);
    #2 rst = 1'b1;
    repeat (4) @(posedge clk);
    for (int i = 0; i < 64; i++) imem[i] = 32'h0;
    for (int i = 0; i < 256; i++) dmem[i] = fill_word(i);
    wr_addr.delete();
    wr_data.delete();
    wr_mask.delete();
    req_size.delete();
    fetch_log.delete();
    prog_len = 0;
  endtask

  task automatic run_prog(int n_writes);
    repeat (12) @(posedge clk);
    #2 rst = 1'b0;
    while (wr_addr.size() < n_writes) @(posedge clk);
  endtask

  // ========================================
  // memory models, respond after 1 to 4 cycles
  initial forever begin
    logic [31:0] a;
    int d;
    @(posedge clk);
    #1;
    if (!rst && ifu_req) begin
      a = ifu_addr;
      fetch_log.push_back(a);
      d = 1 + int'((next_rand() >> 16) % 4);
      repeat (d) @(posedge clk);
      #2;
      ifu_resp  = 1'b1;
      ifu_rdata = ((a - prog_base) < 256) ? imem[(a - prog_base) >> 2] : 32'h0;
      @(posedge clk);
      #2 ifu_resp = 1'b0;
    end
  end

  initial forever begin
    int d;
    @(posedge clk);
    #1;
    if (!rst && lsu_req) begin
      req_size.push_back(lsu_size);
      if (lsu_wen) begin
        wr_addr.push_back(lsu_addr);
        wr_data.push_back(lsu_wdata);
        wr_mask.push_back(lsu_wmask);
        for (int b = 0; b < 4; b++) begin
          if (lsu_wmask[b]) dmem[lsu_addr[9:2]][8*b +: 8] = lsu_wdata[8*b +: 8];
        end
      end
      d = 1 + int'((next_rand() >> 16) % 4);
      repeat (d) @(posedge clk);
      #2;
      lsu_resp  = 1'b1;
      lsu_rdata = dmem[lsu_addr[9:2]];
      @(posedge clk);
      #2 lsu_resp = 1'b0;
    end
  end

  // ========================================
  // directed tests
  task automatic test_arith();
    logic [31:0] sum;
    begin_prog();
    emit(itype(12'd100, 5'd0, 3'b000, 5'd1, 7'b0010011));
    emit(itype(-12'sd37, 5'd0, 3'b000, 5'd2, 7'b0010011));
    emit(rtype(5'd2, 5'd1, 5'd3));
    emit(itype(12'd5, 5'd1, 3'b000, 5'd0, 7'b0010011));
    emit(rtype(5'd0, 5'd3, 5'd4));
    emit(stype(12'h040, 5'd3, 5'd0, 3'b010));
    emit(stype(12'h044, 5'd4, 5'd0, 3'b010));
    emit(stype(12'h048, 5'd0, 5'd0, 3'b010));
    run_prog(3);
    sum = 32'd100 + 32'hffff_ffdb;
    check_eq("arith addr", 32'h40, wr_addr[0]);
    check_eq("arith add", sum, wr_data[0]);
    check_eq("arith add x0", sum, wr_data[1]);
    check_eq("arith x0", 32'h0, wr_data[2]);
  endtask

  task automatic test_byte_store();
    begin_prog();
    emit(itype(12'h0a5, 5'd0, 3'b000, 5'd1, 7'b0010011));
    for (int off = 0; off < 4; off++) begin
      emit(stype(12'h080 + off, 5'd1, 5'd0, 3'b000));
    end
    run_prog(4);
    for (int off = 0; off < 4; off++) begin
      check_eq("sb addr", 32'h80 + off, wr_addr[off]);
      check_eq("sb wmask", 32'(4'b0001 << off), 32'(wr_mask[off]));
      check_eq("sb wdata", 32'h0000_00a5 << (8 * off), wr_data[off]);
      check_eq("sb size", 32'(sz_byte), 32'(req_size[off]));
    end
  endtask

  task automatic test_loads();
    logic [31:0] exp;
    begin_prog();
    for (int off = 0; off < 4; off++) begin
      emit(itype(12'h100 + off, 5'd0, 3'b100, 5'd2, 7'b0000011));
      emit(stype(12'h200 + 4 * off, 5'd2, 5'd0, 3'b010));
    end
    emit(itype(12'h104, 5'd0, 3'b010, 5'd3, 7'b0000011));
    emit(stype(12'h220, 5'd3, 5'd0, 3'b010));
    run_prog(5);
    for (int off = 0; off < 4; off++) begin
      exp = (fill_word(32'h40) >> (8 * off)) & 32'hff;
      check_eq("lbu", exp, wr_data[off]);
      check_eq("lbu size", 32'(sz_byte), 32'(req_size[2 * off]));
      check_eq("sw size", 32'(sz_word), 32'(req_size[2 * off + 1]));
    end
    check_eq("lw", fill_word(32'h41), wr_data[4]);
    check_eq("lw size", 32'(sz_word), 32'(req_size[8]));
  endtask

  task automatic test_jump();
    begin_prog();
    emit(utype(20'h30000, 5'd5));
    emit(itype(12'h021, 5'd5, 3'b000, 5'd6, 7'b1100111));
    // skipped slots store a marker if the jump goes wrong
    for (int i = 2; i < 8; i++) emit(stype(12'h304, 5'd0, 5'd0, 3'b010));
    emit(stype(12'h300, 5'd6, 5'd0, 3'b010));
    run_prog(1);
    check_eq("jalr target", (prog_base + 32'h21) & ~32'h1, fetch_log[2]);
    check_eq("jalr store addr", 32'h300, wr_addr[0]);
    check_eq("jalr link", prog_base + 32'h4 + 32'h4, wr_data[0]);
  endtask

  task automatic test_id_csr();
    begin_prog();
    emit(itype(12'hf11, 5'd0, 3'b010, 5'd1, 7'b1110011));
    emit(stype(12'h040, 5'd1, 5'd0, 3'b010));
    emit(itype(12'hf12, 5'd0, 3'b010, 5'd2, 7'b1110011));
    emit(stype(12'h044, 5'd2, 5'd0, 3'b010));
    emit(itype(-12'sd1, 5'd0, 3'b000, 5'd3, 7'b0010011));
    emit(itype(12'hf11, 5'd3, 3'b001, 5'd0, 7'b1110011));
    emit(itype(12'hf11, 5'd0, 3'b010, 5'd4, 7'b1110011));
    emit(stype(12'h048, 5'd4, 5'd0, 3'b010));
    run_prog(3);
    check_eq("mvendorid", tb_vendor, wr_data[0]);
    check_eq("marchid", tb_arch, wr_data[1]);
    check_eq("mvendorid after write", tb_vendor, wr_data[2]);
  endtask

  task automatic test_mcycle();
    logic [31:0] v;
    v = 32'h0010_0000;
    begin_prog();
    emit(utype(20'h00100, 5'd1));
    emit(itype(12'hb00, 5'd1, 3'b001, 5'd0, 7'b1110011));
    emit(itype(12'hb00, 5'd0, 3'b010, 5'd2, 7'b1110011));
    emit(stype(12'h040, 5'd2, 5'd0, 3'b010));
    emit(itype(12'h700, 5'd0, 3'b000, 5'd3, 7'b0010011));
    emit(itype(12'hb00, 5'd3, 3'b010, 5'd0, 7'b1110011));
    emit(itype(12'hb00, 5'd0, 3'b010, 5'd4, 7'b1110011));
    emit(stype(12'h044, 5'd4, 5'd0, 3'b010));
    run_prog(2);
    checks++;
    assert (wr_data[0] > v && wr_data[0] < v + 200) else begin
      $display("FAIL mcycle read expected above %h and below %h actual %h",
               v, v + 32'd200, wr_data[0]);
      errors++;
    end
    check_eq("mcycle set bits", 32'h700, wr_data[1] & 32'h700);
  endtask

  // ========================================
  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    rst       = 1'b1;
    ifu_resp  = 1'b0;
    ifu_rdata = 32'h0;
    lsu_resp  = 1'b0;
    lsu_rdata = 32'h0;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    test_arith();
    test_byte_store();
    test_loads();
    test_jump();
    test_id_csr();
    test_mcycle();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: core.f
common/rv_isa_pkg.sv
common/mem_bus_pkg.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/csr_file.sv
hdl/execute_writeback.sv
lsu/load_store_unit.sv
hdl/core.sv
dv/tb_clock_gen.sv
dv/core_properties.sv
dv/tb_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_core -f core.f

out=$(./obj_dir/Vtb_core)
echo "$out"

if echo "$out" | grep -qF "** PASS **"; then
  exit 0
fi
exit 1
